// File: src/exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath width
`define EXU_XLEN 32

// shift amount width, log2 of the data width
`define EXU_SAW 5

`endif

// File: src/exu_pkg.sv
`default_nettype none

package exu_pkg;

    typedef enum logic [5:0] {
        OP_AND    = 6'd0,
        OP_OR     = 6'd1,
        OP_NOR    = 6'd2,
        OP_XOR    = 6'd3,
        OP_ADD    = 6'd4,
        OP_ADDU   = 6'd5,
        OP_SUB    = 6'd6,
        OP_SUBU   = 6'd7,
        OP_SLT    = 6'd8,
        OP_SLTU   = 6'd9,
        OP_SLL    = 6'd10,
        OP_SRL    = 6'd11,
        OP_SRA    = 6'd12,
        OP_SLL_SA = 6'd13,
        OP_SRL_SA = 6'd14,
        OP_SRA_SA = 6'd15,
        OP_LUI    = 6'd16,
        OP_CLZ    = 6'd17,
        OP_CLO    = 6'd18,
        OP_PASS   = 6'd19,
        OP_TEQ    = 6'd20,
        OP_TNE    = 6'd21,
        OP_TGE    = 6'd22,
        OP_TGEU   = 6'd23,
        OP_TLT    = 6'd24,
        OP_TLTU   = 6'd25,
        OP_MULT   = 6'd26,
        OP_MULTU  = 6'd27,
        OP_MADD   = 6'd28,
        OP_MADDU  = 6'd29,
        OP_MSUB   = 6'd30,
        OP_MSUBU  = 6'd31,
        OP_DIV    = 6'd32,
        OP_DIVU   = 6'd33,
        OP_MFHI   = 6'd34,
        OP_MFLO   = 6'd35,
        OP_MTHI   = 6'd36,
        OP_MTLO   = 6'd37
    } exu_op_t;

    // ops that run on the multiplier or divider
    function automatic logic is_muldiv(exu_op_t op);
        return op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU,
                          OP_MSUB, OP_MSUBU, OP_DIV, OP_DIVU};
    endfunction

    function automatic logic is_trap(exu_op_t op);
        return op inside {OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
    endfunction

endpackage

`default_nettype wire

// File: src/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module int_alu import exu_pkg::*; (
    input  exu_op_t                op,
    input  logic [`EXU_XLEN-1:0]   src_a,
    input  logic [`EXU_XLEN-1:0]   src_b,
    input  logic [`EXU_SAW-1:0]    sa,
    output logic [`EXU_XLEN-1:0]   alu_result,
    output logic                   overflow,
    output logic                   trap
);

    localparam int W  = `EXU_XLEN;
    localparam int CW = $clog2(`EXU_XLEN) + 1;

    logic           sub_mode;
    logic [W-1:0]   b_in;
    logic [W-1:0]   sum;
    logic           carry;
    logic           lt_s;
    logic           lt_u;
    logic           eq;
    logic [`EXU_SAW-1:0] shamt;
    logic [W-1:0]   shl;
    logic [W-1:0]   shr_l;
    logic [W-1:0]   shr_a;
    logic [W-1:0]   lz_in;
    logic [CW-1:0]  lz_cnt;

    // shared adder, a - b as a + ~b + 1
    assign sub_mode = (op inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTU}) || is_trap(op);
    assign b_in     = src_b ^ {W{sub_mode}};
    assign {carry, sum} = {1'b0, src_a} + {1'b0, b_in} + {{W{1'b0}}, sub_mode};

    assign lt_s = (src_a[W-1] & ~src_b[W-1]) |
                  (~(src_a[W-1] ^ src_b[W-1]) & sum[W-1]);
    assign lt_u = ~carry; // no borrow out means a >= b
    assign eq   = (sum == '0);

    assign overflow = (op == OP_ADD || op == OP_SUB) &&
                      (src_a[W-1] == b_in[W-1]) && (sum[W-1] != src_a[W-1]);

    assign shamt = (op inside {OP_SLL, OP_SRL, OP_SRA}) ? src_a[`EXU_SAW-1:0] : sa;
    assign shl   = src_b << shamt;
    assign shr_l = src_b >> shamt;
    assign shr_a = $signed(src_b) >>> shamt;

    assign lz_in = (op == OP_CLO) ? ~src_a : src_a; // clo counts zeros of the inverse

    always_comb begin
        lz_cnt = CW'(W); // all-zero input
        for (int i = 0; i < W; i++) begin
            if (lz_in[i]) begin
                lz_cnt = CW'(W - 1 - i);
            end
        end
    end

    always_comb begin
        case (op)
            OP_AND:                          alu_result = src_a & src_b;
            OP_OR:                           alu_result = src_a | src_b;
            OP_NOR:                          alu_result = ~(src_a | src_b);
            OP_XOR:                          alu_result = src_a ^ src_b;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: alu_result = sum;
            OP_SLT:                          alu_result = {{(W-1){1'b0}}, lt_s};
            OP_SLTU:                         alu_result = {{(W-1){1'b0}}, lt_u};
            OP_SLL, OP_SLL_SA:               alu_result = shl;
            OP_SRL, OP_SRL_SA:               alu_result = shr_l;
            OP_SRA, OP_SRA_SA:               alu_result = shr_a;
            OP_LUI:                          alu_result = {src_b[W/2-1:0], {(W/2){1'b0}}};
            OP_CLZ, OP_CLO:                  alu_result = {{(W-CW){1'b0}}, lz_cnt};
            OP_PASS:                         alu_result = src_a;
            default:                         alu_result = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_TEQ:  trap = eq;
            OP_TNE:  trap = ~eq;
            OP_TGE:  trap = ~lt_s;
            OP_TGEU: trap = ~lt_u;
            OP_TLT:  trap = lt_s;
            OP_TLTU: trap = lt_u;
            default: trap = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/mult_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module mult_seq (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   start,
    input  logic                   signed_mode,
    input  logic [`EXU_XLEN-1:0]   a,
    input  logic [`EXU_XLEN-1:0]   b,
    output logic [2*`EXU_XLEN-1:0] product,
    output logic                   done
);

    localparam int W  = `EXU_XLEN;
    localparam int CW = $clog2(`EXU_XLEN);

    logic [W-1:0]   mcand;
    logic [2*W-1:0] acc;      // partial sum over remaining multiplier bits
    logic [CW-1:0]  cnt;
    logic           running;
    logic           negate;
    logic [W:0]     partial;

    assign partial = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, mcand} : {(W+1){1'b0}});

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            running <= 1'b0;
            done    <= 1'b0;
            cnt     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(W - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= (signed_mode && a[W-1]) ? -a : a;
            acc    <= {{W{1'b0}}, ((signed_mode && b[W-1]) ? -b : b)};
            negate <= signed_mode && (a[W-1] ^ b[W-1]);
        end else if (running) begin
            acc <= {partial, acc[W-1:1]}; // add then shift right
        end
    end

    assign product = negate ? -acc : acc;

endmodule

`default_nettype wire

// File: src/div_radix2.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module div_radix2 (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 start,
    input  logic                 signed_mode,
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    output logic [`EXU_XLEN-1:0] quotient,
    output logic [`EXU_XLEN-1:0] remainder,
    output logic                 done
);

    localparam int W  = `EXU_XLEN;
    localparam int CW = $clog2(`EXU_XLEN) + 1;

    logic [W-1:0]  dvsr;
    logic [W-1:0]  rem;
    logic [W-1:0]  quo;     // dividend bits shift out, quotient bits shift in
    logic [CW-1:0] cnt;
    logic          running;
    logic          neg_q;
    logic          neg_r;
    logic [W:0]    trial;

    // zero divisor never fails the trial, so quotient goes all ones
    assign trial = {rem, quo[W-1]} - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            running <= 1'b0;
            done    <= 1'b0;
            cnt     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                if (cnt == CW'(W)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dvsr  <= (signed_mode && b[W-1]) ? -b : b;
            quo   <= (signed_mode && a[W-1]) ? -a : a;
            rem   <= '0;
            neg_q <= signed_mode && (a[W-1] ^ b[W-1]);
            neg_r <= signed_mode && a[W-1]; // remainder follows dividend
        end else if (running) begin
            if (cnt != CW'(W)) begin
                if (!trial[W]) begin
                    rem <= trial[W-1:0];
                    quo <= {quo[W-2:0], 1'b1};
                end else begin
                    rem <= {rem[W-2:0], quo[W-1]};
                    quo <= {quo[W-2:0], 1'b0};
                end
            end else begin
                quotient  <= neg_q ? -quo : quo; // final sign fix cycle
                remainder <= neg_r ? -rem : rem;
            end
        end
    end

    cnt_in_range: assert property (@(posedge clk) disable iff (reset)
        running |-> cnt <= CW'(W))
        else $error("divider step counter past data width");

endmodule

`default_nettype wire

// File: src/exu_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_control import exu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   issue,
    input  exu_op_t                op,
    input  logic [`EXU_XLEN-1:0]   alu_result,
    input  logic [`EXU_XLEN-1:0]   src_a,
    input  logic [2*`EXU_XLEN-1:0] product,
    input  logic                   mult_done,
    input  logic [`EXU_XLEN-1:0]   quotient,
    input  logic [`EXU_XLEN-1:0]   remainder,
    input  logic                   div_done,
    output logic                   mult_start,
    output logic                   mult_signed,
    output logic                   div_start,
    output logic                   div_signed,
    output logic                   busy,
    output logic [`EXU_XLEN-1:0]   result,
    output logic [`EXU_XLEN-1:0]   hi,
    output logic [`EXU_XLEN-1:0]   lo
);

    logic [2*`EXU_XLEN-1:0] hilo_next;

    assign mult_start  = issue && (op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU,
                                              OP_MSUB, OP_MSUBU});
    assign mult_signed = op inside {OP_MULT, OP_MADD, OP_MSUB};
    assign div_start   = issue && (op inside {OP_DIV, OP_DIVU});
    assign div_signed  = (op == OP_DIV);

    // op is held until busy drops, so it still selects the accumulate here
    always_comb begin
        case (op)
            OP_MADD, OP_MADDU: hilo_next = {hi, lo} + product;
            OP_MSUB, OP_MSUBU: hilo_next = {hi, lo} - product;
            default:           hilo_next = product;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (mult_done && !flush) begin
            {hi, lo} <= hilo_next;
        end else if (div_done && !flush) begin
            hi <= remainder;
            lo <= quotient;
        end else if (issue && op == OP_MTHI) begin
            hi <= src_a;
        end else if (issue && op == OP_MTLO) begin
            lo <= src_a;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= 1'b0;
        end else if (mult_done || div_done) begin
            busy <= 1'b0;
        end else if (issue && is_muldiv(op)) begin
            busy <= 1'b1;
        end
    end

    always_comb begin
        case (op)
            OP_MFHI: result = hi;
            OP_MFLO: result = lo;
            default: result = alu_result;
        endcase
    end

    issue_while_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !issue)
        else $error("issue while multiply/divide still running");

    // done from either sequencer only belongs to a tracked operation
    done_without_busy: assert property (@(posedge clk) disable iff (reset)
        (mult_done || div_done) |-> busy)
        else $error("done pulse with no operation in flight");

endmodule

`default_nettype wire

// File: src/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_top import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 issue,
    input  exu_op_t              op,
    input  logic [`EXU_XLEN-1:0] src_a,
    input  logic [`EXU_XLEN-1:0] src_b,
    input  logic [`EXU_SAW-1:0]  sa,
    output logic [`EXU_XLEN-1:0] result,
    output logic                 overflow,
    output logic                 trap,
    output logic                 busy,
    output logic [`EXU_XLEN-1:0] hi,
    output logic [`EXU_XLEN-1:0] lo
);

    logic [`EXU_XLEN-1:0]   alu_result;
    logic                   mult_start;
    logic                   mult_signed;
    logic                   mult_done;
    logic [2*`EXU_XLEN-1:0] product;
    logic                   div_start;
    logic                   div_signed;
    logic                   div_done;
    logic [`EXU_XLEN-1:0]   quotient;
    logic [`EXU_XLEN-1:0]   remainder;

    exu_control exu_control_inst (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue       (issue),
        .op          (op),
        .alu_result  (alu_result),
        .src_a       (src_a),
        .product     (product),
        .mult_done   (mult_done),
        .quotient    (quotient),
        .remainder   (remainder),
        .div_done    (div_done),
        .mult_start  (mult_start),
        .mult_signed (mult_signed),
        .div_start   (div_start),
        .div_signed  (div_signed),
        .busy        (busy),
        .result      (result),
        .hi          (hi),
        .lo          (lo)
    );

    int_alu int_alu_inst (
        .op         (op),
        .src_a      (src_a),
        .src_b      (src_b),
        .sa         (sa),
        .alu_result (alu_result),
        .overflow   (overflow),
        .trap       (trap)
    );

    mult_seq mult_seq_inst (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .start       (mult_start),
        .signed_mode (mult_signed),
        .a           (src_a),
        .b           (src_b),
        .product     (product),
        .done        (mult_done)
    );

    div_radix2 div_radix2_inst (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .start       (div_start),
        .signed_mode (div_signed),
        .a           (src_a),
        .b           (src_b),
        .quotient    (quotient),
        .remainder   (remainder),
        .done        (div_done)
    );

endmodule

`default_nettype wire

// File: sim/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exu_tb import exu_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        flush;
    logic        issue;
    exu_op_t     op;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [4:0]  sa;
    logic [31:0] result;
    logic        overflow;
    logic        trap;
    logic        busy;
    logic [31:0] hi;
    logic [31:0] lo;

    int          errors;
    int          checks;
    int          cases_run;
    bit          timed_out;

    exu_top exu_top_inst (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .issue    (issue),
        .op       (op),
        .src_a    (src_a),
        .src_b    (src_b),
        .sa       (sa),
        .result   (result),
        .overflow (overflow),
        .trap     (trap),
        .busy     (busy),
        .hi       (hi),
        .lo       (lo)
    );

    always #5 clk = ~clk;

    task automatic wait_not_busy(input int limit);
        int n;
        n = 0;
        while (busy && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("timeout: busy still high after %0d cycles", limit);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // issue for one cycle and hold operands until busy drops
    task automatic drive_op(input exu_op_t code, input logic [31:0] a,
                            input logic [31:0] b, input logic [4:0] s);
        @(negedge clk);
        op    = code;
        src_a = a;
        src_b = b;
        sa    = s;
        issue = 1'b1;
        @(negedge clk);
        issue = 1'b0;
        if (is_muldiv(code)) begin
            wait_not_busy(200);
        end
    endtask

    task automatic check_outputs(input int n, input bit has_result,
                                 input logic [31:0] exp_result, input logic exp_ov,
                                 input logic exp_trap, input logic [31:0] exp_hi,
                                 input logic [31:0] exp_lo);
        checks++;
        if (has_result && result !== exp_result) begin
            $display("Mismatch result in case %0d: got %h expected %h", n, result, exp_result);
            errors++;
        end
        if (overflow !== exp_ov) begin
            $display("Mismatch overflow in case %0d: got %h expected %h", n, overflow, exp_ov);
            errors++;
        end
        if (trap !== exp_trap) begin
            $display("Mismatch trap in case %0d: got %h expected %h", n, trap, exp_trap);
            errors++;
        end
        if (hi !== exp_hi) begin
            $display("Mismatch hi in case %0d: got %h expected %h", n, hi, exp_hi);
            errors++;
        end
        if (lo !== exp_lo) begin
            $display("Mismatch lo in case %0d: got %h expected %h", n, lo, exp_lo);
            errors++;
        end
        if (busy !== 1'b0) begin
            $display("case %0d left busy high after it completed", n);
            errors++;
        end
    endtask

    task automatic run_cases();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f_op, f_a, f_b, f_sa, f_res, f_ov, f_trap, f_hi, f_lo;
        exu_op_t     code;
        bit          has_result;
        fd = $fopen("sim/exu_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/exu_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && !timed_out) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                             f_op, f_a, f_b, f_sa, f_res, f_ov, f_trap, f_hi, f_lo);
            if (fields == 9) begin // comment and blank lines give fewer fields
                code = exu_op_t'(f_op[5:0]);
                cases_run++;
                drive_op(code, f_a, f_b, f_sa[4:0]);
                has_result = !is_muldiv(code) && !is_trap(code) &&
                             code != OP_MTHI && code != OP_MTLO;
                if (!timed_out) begin
                    check_outputs(cases_run, has_result, f_res, f_ov[0], f_trap[0], f_hi, f_lo);
                end
            end
        end
        $fclose(fd);
        if (cases_run == 0) begin
            $display("no cases were read from sim/exu_cases.txt");
            errors++;
        end
    endtask

    task automatic run_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expect_sum;
        logic        expect_ov;
        exu_op_t     code;
        for (int i = 0; i < 40; i++) begin
            a = $urandom;
            b = $urandom;
            case ($urandom_range(3, 0))
                0:       code = OP_ADD;
                1:       code = OP_ADDU;
                2:       code = OP_SUB;
                default: code = OP_SUBU;
            endcase
            if (code == OP_SUB || code == OP_SUBU) begin
                expect_sum = a - b;
            end else begin
                expect_sum = a + b;
            end
            expect_ov = 1'b0;
            if (code == OP_ADD) begin
                expect_ov = (a[31] == b[31]) && (expect_sum[31] != a[31]);
            end
            if (code == OP_SUB) begin
                expect_ov = (a[31] != b[31]) && (expect_sum[31] != a[31]);
            end
            drive_op(code, a, b, 5'd0);
            checks++;
            if (result !== expect_sum) begin
                $display("Mismatch result in random %0d: got %h expected %h",
                         i, result, expect_sum);
                errors++;
            end
            if (overflow !== expect_ov) begin
                $display("Mismatch overflow in random %0d: got %h expected %h",
                         i, overflow, expect_ov);
                errors++;
            end
        end
    endtask

    task automatic run_flush();
        logic [31:0] hi_before;
        logic [31:0] lo_before;
        hi_before = hi;
        lo_before = lo;
        @(negedge clk);
        op    = OP_DIVU;
        src_a = 32'h0001_2345;
        src_b = 32'h0000_0007;
        issue = 1'b1;
        @(negedge clk);
        issue = 1'b0;
        repeat (5) @(negedge clk); // partway into the divide
        checks++;
        if (!busy) begin
            $display("busy was low before the flush was applied");
            errors++;
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        wait_not_busy(200);
        repeat (40) @(negedge clk); // past where the divide would have ended
        if (hi !== hi_before) begin
            $display("Mismatch hi after flush: got %h expected %h", hi, hi_before);
            errors++;
        end
        if (lo !== lo_before) begin
            $display("Mismatch lo after flush: got %h expected %h", lo, lo_before);
            errors++;
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        flush     = 1'b0;
        issue     = 1'b0;
        op        = OP_PASS;
        src_a     = '0;
        src_b     = '0;
        sa        = '0;
        errors    = 0;
        checks    = 0;
        cases_run = 0;
        timed_out = 1'b0;
        void'($urandom(32'h0202_393b));
        repeat (16) @(negedge clk);
        reset = 1'b0;
        run_cases();
        if (!timed_out) begin
            run_random();
        end
        if (!timed_out) begin
            run_flush();
        end
        $display("file cases %0d, checks %0d, errors %0d", cases_run, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/exu_cases.txt
# op src_a src_b sa result overflow trap hi lo (hex, op as exu_op_t code)
# result is ignored on mul/div, trap and mthi/mtlo lines
00 f0f0ff00 0ff00f0f 00 00f00f00 0 0 00000000 00000000 and
03 12345678 ffff0000 00 edcb5678 0 0 00000000 00000000 xor
0a 00000004 00000081 00 00000810 0 0 00000000 00000000 sll by src_a
0c 00000008 80001234 00 ff800012 0 0 00000000 00000000 sra sign fill
0f 00000000 80000000 1f ffffffff 0 0 00000000 00000000 sra_sa by 31
10 00000000 0000abcd 00 abcd0000 0 0 00000000 00000000 lui
11 00000000 00000000 00 00000020 0 0 00000000 00000000 clz of zero
11 00010000 00000000 00 0000000f 0 0 00000000 00000000 clz
12 fff00000 00000000 00 0000000c 0 0 00000000 00000000 clo
08 ffffffff 00000001 00 00000001 0 0 00000000 00000000 slt
09 ffffffff 00000001 00 00000000 0 0 00000000 00000000 sltu
04 7fffffff 00000001 00 80000000 1 0 00000000 00000000 add overflow
05 7fffffff 00000001 00 80000000 0 0 00000000 00000000 addu
06 80000000 00000001 00 7fffffff 1 0 00000000 00000000 sub overflow
07 80000000 00000001 00 7fffffff 0 0 00000000 00000000 subu
14 00000005 00000005 00 00000000 0 1 00000000 00000000 teq equal
15 00000005 00000005 00 00000000 0 0 00000000 00000000 tne equal
16 ffffffff 00000001 00 00000000 0 0 00000000 00000000 tge signed less
17 ffffffff 00000001 00 00000000 0 1 00000000 00000000 tgeu unsigned greater
18 00000001 00000001 00 00000000 0 0 00000000 00000000 tlt equal
19 00000001 ffffffff 00 00000000 0 1 00000000 00000000 tltu unsigned less
1a fffffffe 00000003 00 00000000 0 0 ffffffff fffffffa mult
1b ffffffff 00000002 00 00000000 0 0 00000001 fffffffe multu
1c 00000002 00000003 00 00000000 0 0 00000002 00000004 madd
1e ffffffff 00000004 00 00000000 0 0 00000002 00000008 msub
22 00000000 00000000 00 00000002 0 0 00000002 00000008 mfhi
23 00000000 00000000 00 00000008 0 0 00000002 00000008 mflo
20 fffffff9 00000002 00 00000000 0 0 ffffffff fffffffd div negative dividend
21 00000064 00000007 00 00000000 0 0 00000002 0000000e divu
21 12345678 00000000 00 00000000 0 0 12345678 ffffffff divu by zero
20 fffffff9 00000000 00 00000000 0 0 fffffff9 00000001 div by zero
24 aaaa5555 00000000 00 00000000 0 0 aaaa5555 00000001 mthi
25 0000beef 00000000 00 00000000 0 0 aaaa5555 0000beef mtlo

// File: list.f
+incdir+src
src/exu_pkg.sv
src/int_alu.sv
src/mult_seq.sv
src/div_radix2.sv
src/exu_control.sv
src/exu_top.sv
sim/exu_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module exu_tb -f list.f > build.log 2>&1 \
    && ./obj_dir/Vexu_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
